/* source/csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define XLEN            32

`define CSR_HART_ID     32'h0000_0000

// MXL = 1 (RV32) and the I extension bit.
`define CSR_MISA_RESET  32'h4000_0100

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine information registers, read-only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12
`define CSR_MIMPID      12'hF13
`define CSR_MHARTID     12'hF14

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine trap setup and handling.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSTATUSH    12'h310
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344

`endif

/* source/csr_pkg.sv */
`default_nettype none

`include "csr_settings.svh"

package csr_pkg;

    // Encoded as funct3[1:0] of the CSR instructions.
    typedef enum logic [1:0] {
        OP_RW = 2'b01,
        OP_RS = 2'b10,
        OP_RC = 2'b11
    } csr_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode to execute.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        csr_op_e           op;
        logic [11:0]       addr;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  operand;    // rs1 value or zero-extended uimm.
        logic              wr_intent;
    } csr_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute to result.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [4:0]        rd;
        logic [`XLEN-1:0]  data;       // Old CSR value.
        logic              illegal;
    } csr_wb_t;

endpackage

`default_nettype wire

/* source/csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_decode (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                instr_valid_i,
    input  logic [`XLEN-1:0]    instr_i,
    input  logic [`XLEN-1:0]    rs1_data_i,
    output logic                req_valid_o,
    output csr_pkg::csr_req_t   req_o
);

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [4:0]         rs1_field;
    logic               is_csr;
    csr_pkg::csr_req_t  req_d;
    logic               req_valid_q;
    csr_pkg::csr_req_t  req_q;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign rs1_field = instr_i[19:15];

    // funct3 000 and 100 are not CSR accesses.
    assign is_csr = (opcode == OPCODE_SYSTEM) && (funct3[1:0] != 2'b00);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request fields.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        req_d.op   = csr_pkg::csr_op_e'(funct3[1:0]);
        req_d.addr = instr_i[31:20];
        req_d.rd   = instr_i[11:7];

        if (funct3[2]) begin
            req_d.operand = {{(`XLEN-5){1'b0}}, rs1_field};  // Immediate form.
        end else begin
            req_d.operand = rs1_data_i;
        end

        // Set and clear with a zero rs1 field only read.
        req_d.wr_intent = (req_d.op == csr_pkg::OP_RW) || (rs1_field != 5'd0);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk, negedge reset_n) begin
        if (~reset_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= instr_valid_i & is_csr;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i & is_csr) begin
            req_q <= req_d;
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;

endmodule

`default_nettype wire

/* source/csr_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_execute (
    input  logic                req_valid_i,
    input  csr_pkg::csr_req_t   req_i,
    input  logic [`XLEN-1:0]    csr_rdata_i,
    input  logic                csr_hit_i,
    output logic [11:0]         csr_raddr_o,
    output logic                csr_we_o,
    output logic [11:0]         csr_waddr_o,
    output logic [`XLEN-1:0]    csr_wdata_o,
    output logic                wb_valid_o,
    output csr_pkg::csr_wb_t    wb_o
);

    logic [`XLEN-1:0] new_value;
    logic             read_only;
    logic             illegal;

    assign csr_raddr_o = req_i.addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // New value.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (req_i.op)
            csr_pkg::OP_RS: new_value = csr_rdata_i | req_i.operand;
            csr_pkg::OP_RC: new_value = csr_rdata_i & ~req_i.operand;
            default:        new_value = req_i.operand;   // OP_RW.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Legality.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign read_only = &req_i.addr[11:10];
    assign illegal   = ~csr_hit_i | (req_i.wr_intent & read_only);

    // Write port.
    assign csr_we_o    = req_valid_i & ~illegal & req_i.wr_intent;
    assign csr_waddr_o = req_i.addr;
    assign csr_wdata_o = new_value;

    // The old value goes back to rd.
    assign wb_valid_o   = req_valid_i;
    assign wb_o.rd      = req_i.rd;
    assign wb_o.data    = csr_rdata_i;
    assign wb_o.illegal = illegal;

endmodule

`default_nettype wire

/* source/csr_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_regfile (
    input  logic                clk,
    input  logic                reset_n,
    input  logic [11:0]         raddr_i,
    output logic [`XLEN-1:0]    rdata_o,
    output logic                hit_o,
    input  logic                we_i,
    input  logic [11:0]         waddr_i,
    input  logic [`XLEN-1:0]    wdata_i
);

    localparam int NUM_RW = 10;

    localparam int MSTATUS_IDX  = 0;
    localparam int MISA_IDX     = 1;
    localparam int MIE_IDX      = 2;
    localparam int MTVEC_IDX    = 3;
    localparam int MSTATUSH_IDX = 4;
    localparam int MSCRATCH_IDX = 5;
    localparam int MEPC_IDX     = 6;
    localparam int MCAUSE_IDX   = 7;
    localparam int MTVAL_IDX    = 8;
    localparam int MIP_IDX      = 9;

    // Same order as the indices above.
    localparam logic [11:0] RW_ADDR [NUM_RW] = '{
        `CSR_MSTATUS,
        `CSR_MISA,
        `CSR_MIE,
        `CSR_MTVEC,
        `CSR_MSTATUSH,
        `CSR_MSCRATCH,
        `CSR_MEPC,
        `CSR_MCAUSE,
        `CSR_MTVAL,
        `CSR_MIP
    };

    logic [`XLEN-1:0]  csr_q [NUM_RW];
    logic [NUM_RW-1:0] wr_sel;
    logic [NUM_RW-1:0] rw_hit;
    logic              ro_hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar g = 0; g < NUM_RW; g++) begin : g_rw
        assign wr_sel[g] = we_i & (waddr_i == RW_ADDR[g]);
        assign rw_hit[g] = (raddr_i == RW_ADDR[g]);

        always_ff @(posedge clk, negedge reset_n) begin
            if (~reset_n) begin
                csr_q[g] <= (g == MISA_IDX) ? `CSR_MISA_RESET : '0;
            end else if (wr_sel[g]) begin
                csr_q[g] <= wdata_i;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ro_hit = (raddr_i == `CSR_MVENDORID)
                  | (raddr_i == `CSR_MARCHID)
                  | (raddr_i == `CSR_MIMPID)
                  | (raddr_i == `CSR_MHARTID);

    assign hit_o = ro_hit | (|rw_hit);

    // mvendorid, marchid and mimpid read zero and add no term.
    assign rdata_o = {`XLEN{raddr_i == `CSR_MHARTID}}  & `CSR_HART_ID
                   | {`XLEN{rw_hit[MSTATUS_IDX]}}      & csr_q[MSTATUS_IDX]
                   | {`XLEN{rw_hit[MISA_IDX]}}         & csr_q[MISA_IDX]
                   | {`XLEN{rw_hit[MIE_IDX]}}          & csr_q[MIE_IDX]
                   | {`XLEN{rw_hit[MTVEC_IDX]}}        & csr_q[MTVEC_IDX]
                   | {`XLEN{rw_hit[MSTATUSH_IDX]}}     & csr_q[MSTATUSH_IDX]
                   | {`XLEN{rw_hit[MSCRATCH_IDX]}}     & csr_q[MSCRATCH_IDX]
                   | {`XLEN{rw_hit[MEPC_IDX]}}         & csr_q[MEPC_IDX]
                   | {`XLEN{rw_hit[MCAUSE_IDX]}}       & csr_q[MCAUSE_IDX]
                   | {`XLEN{rw_hit[MTVAL_IDX]}}        & csr_q[MTVAL_IDX]
                   | {`XLEN{rw_hit[MIP_IDX]}}          & csr_q[MIP_IDX];

endmodule

`default_nettype wire

/* source/csr_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_result (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                wb_valid_i,
    input  csr_pkg::csr_wb_t    wb_i,
    output logic                rd_we_o,
    output logic [4:0]          rd_addr_o,
    output logic [`XLEN-1:0]    rd_data_o,
    output logic                illegal_o
);

    logic rd_we_d;

    // x0 is never written.
    assign rd_we_d = wb_valid_i & ~wb_i.illegal & (wb_i.rd != 5'd0);

    always_ff @(posedge clk, negedge reset_n) begin
        if (~reset_n) begin
            rd_we_o   <= 1'b0;
            illegal_o <= 1'b0;
            rd_addr_o <= '0;
            rd_data_o <= '0;
        end else begin
            rd_we_o   <= rd_we_d;
            illegal_o <= wb_valid_i & wb_i.illegal;  // One-cycle pulse.
            if (wb_valid_i) begin
                rd_addr_o <= wb_i.rd;
                rd_data_o <= wb_i.data;
            end
        end
    end

endmodule

`default_nettype wire

/* source/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                instr_valid_i,
    input  logic [`XLEN-1:0]    instr_i,
    input  logic [`XLEN-1:0]    rs1_data_i,
    output logic                rd_we_o,
    output logic [4:0]          rd_addr_o,
    output logic [`XLEN-1:0]    rd_data_o,
    output logic                illegal_o
);

    logic               req_valid;
    csr_pkg::csr_req_t  req;
    logic [11:0]        csr_raddr;
    logic [`XLEN-1:0]   csr_rdata;
    logic               csr_hit;
    logic               csr_we;
    logic [11:0]        csr_waddr;
    logic [`XLEN-1:0]   csr_wdata;
    logic               wb_valid;
    csr_pkg::csr_wb_t   wb;

    csr_decode csr_decode_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .req_valid_o   (req_valid),
        .req_o         (req)
    );

    csr_execute csr_execute_i (
        .req_valid_i (req_valid),
        .req_i       (req),
        .csr_rdata_i (csr_rdata),
        .csr_hit_i   (csr_hit),
        .csr_raddr_o (csr_raddr),
        .csr_we_o    (csr_we),
        .csr_waddr_o (csr_waddr),
        .csr_wdata_o (csr_wdata),
        .wb_valid_o  (wb_valid),
        .wb_o        (wb)
    );

    csr_regfile csr_regfile_i (
        .clk     (clk),
        .reset_n (reset_n),
        .raddr_i (csr_raddr),
        .rdata_o (csr_rdata),
        .hit_o   (csr_hit),
        .we_i    (csr_we),
        .waddr_i (csr_waddr),
        .wdata_i (csr_wdata)
    );

    csr_result csr_result_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .wb_valid_i (wb_valid),
        .wb_i       (wb),
        .rd_we_o    (rd_we_o),
        .rd_addr_o  (rd_addr_o),
        .rd_data_o  (rd_data_o),
        .illegal_o  (illegal_o)
    );

endmodule

`default_nettype wire

/* tb/csr_unit_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit_asserts (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                rd_we_i,
    input  logic [4:0]          rd_addr_i,
    input  logic [`XLEN-1:0]    rd_data_i,
    input  logic                illegal_i
);

    int unsigned fail_count = 0;

    // An item either writes rd or is illegal but never both.
    assert property (@(posedge clk) disable iff (!reset_n) !(rd_we_i && illegal_i))
        else begin
            fail_count++;
            $error("rd_we_o and illegal_o are high in the same cycle.");
        end

    assert property (@(posedge clk) disable iff (!reset_n) rd_we_i |-> (rd_addr_i != 5'd0))
        else begin
            fail_count++;
            $error("rd_we_o is high with rd_addr_o equal to zero.");
        end

    // Outputs are cleared while reset is held.
    assert property (@(posedge clk) !reset_n |-> (!rd_we_i && !illegal_i
                                                  && rd_addr_i == '0 && rd_data_i == '0))
        else begin
            fail_count++;
            $error("Outputs are not low during reset.");
        end

endmodule

bind csr_unit csr_unit_asserts csr_unit_asserts_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .rd_we_i   (rd_we_o),
    .rd_addr_i (rd_addr_o),
    .rd_data_i (rd_data_o),
    .illegal_i (illegal_o)
);

`default_nettype wire

/* tb/csr_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 4000;
    localparam int NUM_CSR      = 14;
    localparam int NUM_ADDR     = 18;
    localparam int TIMEOUT_NS   = (NUM_INSTR + NUM_CSR + RESET_CYCLES) * CLK_PERIOD + 2000;

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;

    // The fourteen machine CSRs first, then a few unimplemented addresses.
    localparam logic [11:0] ADDR_TABLE [NUM_ADDR] = '{
        `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID,
        `CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MTVEC, `CSR_MSTATUSH,
        `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP,
        12'h7C0, 12'hB00, 12'h345, 12'hF15
    };

    typedef struct packed {
        logic             rd_we;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
        logic             illegal;
    } expect_t;

    logic             clk;
    logic             reset_n;
    logic             instr_valid;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] rs1_data;
    logic             rd_we;
    logic [4:0]       rd_addr;
    logic [`XLEN-1:0] rd_data;
    logic             illegal;

    logic [`XLEN-1:0] model_csr [4096];
    expect_t          pending [$];     // One entry per cycle that falls due two cycles later.

    csr_unit csr_unit_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .rs1_data_i    (rs1_data),
        .rd_we_o       (rd_we),
        .rd_addr_o     (rd_addr),
        .rd_data_o     (rd_data),
        .illegal_o     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic implemented(input logic [11:0] addr);
        logic found;
        found = 1'b0;
        for (int i = 0; i < NUM_CSR; i++) begin
            if (ADDR_TABLE[i] == addr) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    function automatic logic [`XLEN-1:0] csr_word(input logic [11:0] addr,
                                                  input logic [4:0] rs1f,
                                                  input logic [2:0] f3,
                                                  input logic [4:0] rd);
        return {addr, rs1f, f3, rd, OPCODE_SYSTEM};
    endfunction

    task automatic reset_model();
        for (int a = 0; a < 4096; a++) begin
            model_csr[a] = '0;
        end
        model_csr[`CSR_MISA]    = `CSR_MISA_RESET;
        model_csr[`CSR_MHARTID] = `CSR_HART_ID;
    endtask

    task automatic apply_model(input logic valid, input logic [`XLEN-1:0] word,
                               input logic [`XLEN-1:0] data, output expect_t exp);
        logic [2:0]       f3;
        logic [4:0]       rs1f;
        logic [11:0]      addr;
        logic [`XLEN-1:0] operand;
        logic [`XLEN-1:0] old_value;
        logic             write;
        f3   = word[14:12];
        rs1f = word[19:15];
        addr = word[31:20];
        exp  = '0;
        if (valid && word[6:0] == OPCODE_SYSTEM && f3[1:0] != 2'b00) begin
            operand = f3[2] ? {{(`XLEN-5){1'b0}}, rs1f} : data;
            write   = (f3[1:0] == csr_pkg::OP_RW) || (rs1f != 5'd0);
            if (!implemented(addr) || (write && addr[11:10] == 2'b11)) begin
                exp.illegal = 1'b1;
            end else begin
                old_value = model_csr[addr];
                if (write) begin
                    case (f3[1:0])
                        csr_pkg::OP_RS: model_csr[addr] = old_value | operand;
                        csr_pkg::OP_RC: model_csr[addr] = old_value & ~operand;
                        default:        model_csr[addr] = operand;
                    endcase
                end
                if (word[11:7] != 5'd0) begin
                    exp.rd_we = 1'b1;
                    exp.rd    = word[11:7];
                    exp.data  = old_value;
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic compare_outputs(input expect_t exp);
        check(rd_we, exp.rd_we, "rd_we_o");
        check(illegal, exp.illegal, "illegal_o");
        if (exp.rd_we) begin
            check(rd_addr, exp.rd, "rd_addr_o");
            check(rd_data, exp.data, "rd_data_o");
        end
    endtask

    task automatic issue(input logic valid, input logic [`XLEN-1:0] word,
                         input logic [`XLEN-1:0] data);
        expect_t exp;
        expect_t due;
        @(negedge clk);
        if (pending.size() == 2) begin
            due = pending.pop_front();
            compare_outputs(due);
        end
        instr_valid = valid;
        instr       = word;
        rs1_data    = data;
        apply_model(valid, word, data, exp);
        pending.push_back(exp);
    endtask

    task automatic random_issue();
        int unsigned      kind;
        int unsigned      pick;
        logic [2:0]       f3;
        logic [4:0]       rs1f;
        logic [4:0]       rd;
        logic [`XLEN-1:0] word;
        kind = $urandom_range(9);
        word = $urandom();
        if (kind == 0) begin
            issue(1'b0, word, $urandom());  // Idle cycle with junk on the bus.
        end else if (kind == 1) begin
            if (word[0]) begin
                word[6:0] = OPCODE_OP;
            end else begin
                word[6:0]   = OPCODE_SYSTEM;  // ECALL/EBREAK class.
                word[13:12] = 2'b00;
            end
            issue(1'b1, word, $urandom());
        end else begin
            pick    = $urandom_range(NUM_ADDR - 1);
            f3[2]   = 1'($urandom_range(1));
            f3[1:0] = 2'($urandom_range(3, 1));
            rs1f    = ($urandom_range(3) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
            rd      = ($urandom_range(3) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
            issue(1'b1, csr_word(ADDR_TABLE[pick], rs1f, f3, rd), $urandom());
        end
    endtask

    always @(csr_unit_i.csr_unit_asserts_i.fail_count) begin
        if (csr_unit_i.csr_unit_asserts_i.fail_count != 0) begin
            $display("An assertion in csr_unit_asserts failed at %0t.", $time);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped at a failed assertion.");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the run did not finish within %0d ns.", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        void'($urandom(32'hf820));
        reset_n     = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        reset_model();
        #1 reset_n = 1'b0;  // Falling reset edge ahead of the first rising clock edge.
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Every CSR read once after reset by CSRRS with rs1 = x0.
        for (int i = 0; i < NUM_CSR; i++) begin
            issue(1'b1, csr_word(ADDR_TABLE[i], 5'd0, 3'b010, 5'(i + 1)), $urandom());
        end

        for (int n = 0; n < NUM_INSTR; n++) begin
            random_issue();
        end

        issue(1'b0, '0, '0);
        issue(1'b0, '0, '0);
        if (csr_unit_i.csr_unit_asserts_i.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("An assertion in csr_unit_asserts failed during the run.");
            $display("RESULT: FAIL");
            $fatal(1, "Assertion failures were recorded.");
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/csr_pkg.sv
source/csr_decode.sv
source/csr_execute.sv
source/csr_regfile.sv
source/csr_result.sv
source/csr_unit.sv
tb/csr_unit_asserts.sv
tb/csr_unit_tb.sv

/* Bender.yml */
package:
  name: csr_unit

sources:
  - include_dirs:
      - source
    files:
      - source/csr_pkg.sv
      - source/csr_decode.sv
      - source/csr_execute.sv
      - source/csr_regfile.sv
      - source/csr_result.sv
      - source/csr_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/csr_unit_asserts.sv
      - tb/csr_unit_tb.sv
